// ==== design/cpu_pkg.sv ====
/*
 * CPU package
 * Shared word types, RV32I opcodes and the ALU operation set
 */
package cpu_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] inst_t;
    typedef logic [6:0]  opcode_t;

    //////////////////////////////////////////////////
    // Major opcodes
    //////////////////////////////////////////////////
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;

    // Branch conditions in funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // ADDI x0, x0, 0
    localparam inst_t NOP_INST = 32'h0000_0013;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

endpackage

// ==== design/cpu_intf.sv ====
/*
 * Pipeline interfaces
 * id_ex_if carries a decoded instruction into execute,
 * wb_if carries the writeback register contents
 */
interface id_ex_if import cpu_pkg::*; ();
    logic     valid;
    xlen_t    pc;
    inst_t    inst;
    reg_idx_t rd;
    logic     rd_we;
    alu_op_e  alu_op;
    xlen_t    op_a;
    xlen_t    op_b;
    reg_idx_t rs1;
    reg_idx_t rs2;
    // Operand came from a register and may be replaced by a newer value
    logic     fwd_a_en;
    logic     fwd_b_en;

    modport decode (output valid, pc, inst, rd, rd_we, alu_op, op_a, op_b,
                    rs1, rs2, fwd_a_en, fwd_b_en);
    modport execute (input valid, pc, inst, rd, rd_we, alu_op, op_a, op_b,
                     rs1, rs2, fwd_a_en, fwd_b_en);
endinterface

interface wb_if import cpu_pkg::*; ();
    logic     valid;
    xlen_t    pc;
    inst_t    inst;
    reg_idx_t rd;
    logic     rd_we;
    xlen_t    rd_data;

    modport execute (output valid, pc, inst, rd, rd_we, rd_data);
    modport decode (input valid, rd, rd_we, rd_data);
endinterface

// ==== design/fetch_stage.sv ====
/*
 * Fetch stage
 * Program counter and the fetch/decode pipeline register
 */
module fetch_stage import cpu_pkg::*; #(
    parameter xlen_t RESET_PC = 32'h0000_0000
) (
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  redirect_i,
    input  xlen_t target_i,
    input  logic  hold_i,
    input  inst_t imem_data_i,
    output xlen_t imem_addr_o,
    output logic  if_valid_o,
    output xlen_t if_pc_o,
    output inst_t if_inst_o
);

    xlen_t pc;

    assign imem_addr_o = pc;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc <= RESET_PC;
        end else if (redirect_i) begin
            pc <= target_i;
        end else if (!hold_i) begin
            pc <= pc + 32'd4;
        end
    end

    //////////////////////////////////////////////////
    // Fetch/decode register
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            if_valid_o <= 1'b0;
        end else if (!hold_i) begin
            if_valid_o <= !redirect_i;
        end
    end

    // Wrong-path slot becomes a NOP
    always_ff @(posedge clk) begin
        if (!hold_i) begin
            if_pc_o   <= pc;
            if_inst_o <= redirect_i ? NOP_INST : imem_data_i;
        end
    end

    a_no_redirect_on_hold: assert property (
        @(posedge clk) disable iff (!rst_n_i) !(redirect_i && hold_i)
    ) else $error("redirect and hold raised together");

endmodule

// ==== design/decoder.sv ====
/*
 * Instruction decoder
 * Splits an RV32I word into register indices, immediate and controls
 */
module decoder import cpu_pkg::*; (
    input  inst_t    inst_i,
    output reg_idx_t rs1_o,
    output reg_idx_t rs2_o,
    output reg_idx_t rd_o,
    output xlen_t    imm_o,
    output logic     rd_we_o,
    output logic     use_rs1_o,
    output logic     use_rs2_o,
    output logic     src_a_pc_o,
    output logic     src_b_imm_o,
    output logic     is_jal_o,
    output logic     is_jalr_o,
    output logic     is_branch_o,
    output alu_op_e  alu_op_o
);

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       writes;

    function automatic alu_op_e alu_from_f3(logic [2:0] f3, logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign rs1_o  = inst_i[19:15];
    assign rs2_o  = inst_i[24:20];
    assign rd_o   = inst_i[11:7];

    always_comb begin
        writes      = 1'b1;
        use_rs1_o   = 1'b0;
        use_rs2_o   = 1'b0;
        src_a_pc_o  = 1'b0;
        src_b_imm_o = 1'b0;
        is_jal_o    = 1'b0;
        is_jalr_o   = 1'b0;
        is_branch_o = 1'b0;
        alu_op_o    = ALU_ADD;
        imm_o       = {{20{inst_i[31]}}, inst_i[31:20]};
        case (opcode)
            OPC_OP: begin
                use_rs1_o = 1'b1;
                use_rs2_o = 1'b1;
                alu_op_o  = alu_from_f3(funct3, funct7[5]);
                // M extension shares this opcode
                writes    = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
            end
            OPC_OP_IMM: begin
                use_rs1_o   = 1'b1;
                src_b_imm_o = 1'b1;
                alu_op_o    = alu_from_f3(funct3, funct7[5] && funct3 == 3'b101);
            end
            OPC_LUI, OPC_AUIPC: begin
                imm_o       = {inst_i[31:12], 12'b0};
                src_b_imm_o = 1'b1;
                src_a_pc_o  = (opcode == OPC_AUIPC);
                alu_op_o    = (opcode == OPC_LUI) ? ALU_PASS_B : ALU_ADD;
            end
            OPC_JAL: begin
                imm_o      = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20],
                              inst_i[30:21], 1'b0};
                src_a_pc_o = 1'b1;
                is_jal_o   = 1'b1;
            end
            OPC_JALR: begin
                use_rs1_o  = 1'b1;
                src_a_pc_o = 1'b1;
                is_jalr_o  = 1'b1;
            end
            OPC_BRANCH: begin
                imm_o       = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25],
                               inst_i[11:8], 1'b0};
                use_rs1_o   = 1'b1;
                use_rs2_o   = 1'b1;
                is_branch_o = 1'b1;
                writes      = 1'b0;
            end
            default: writes = 1'b0;
        endcase
    end

    assign rd_we_o = writes && (rd_o != '0);

endmodule

// ==== design/reg_file.sv ====
/*
 * Register file
 * x1..x31 with x0 hardwired to zero, writes visible to same-cycle reads
 */
module reg_file import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  reg_idx_t rs1_i,
    input  reg_idx_t rs2_i,
    output xlen_t    rdata1_o,
    output xlen_t    rdata2_o,
    wb_if.decode     wb
);

    xlen_t regs [1:31];
    logic  wr_en;

    assign wr_en = wb.valid && wb.rd_we;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.rd] <= wb.rd_data;
        end
    end

    // Write-first bypass
    assign rdata1_o = (rs1_i == '0) ? '0 :
                      (wr_en && rs1_i == wb.rd) ? wb.rd_data : regs[rs1_i];
    assign rdata2_o = (rs2_i == '0) ? '0 :
                      (wr_en && rs2_i == wb.rd) ? wb.rd_data : regs[rs2_i];

    a_no_x0_write: assert property (
        @(posedge clk) disable iff (!rst_n_i) wb.rd_we |-> wb.rd != '0
    ) else $error("write to x0 reached the register file");

endmodule

// ==== design/decode_stage.sv ====
/*
 * Decode stage
 * Register read, branch and jump resolution, hazard stall,
 * and the decode/execute register
 */
module decode_stage import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     if_valid_i,
    input  xlen_t    if_pc_i,
    input  inst_t    if_inst_i,
    output logic     redirect_o,
    output xlen_t    target_o,
    output logic     hold_o,
    id_ex_if.decode  idex,
    wb_if.decode     wb
);

    reg_idx_t dec_rs1, dec_rs2, dec_rd;
    xlen_t    dec_imm;
    alu_op_e  dec_alu_op;
    logic     dec_rd_we, dec_use_rs1, dec_use_rs2, dec_src_a_pc, dec_src_b_imm;
    logic     dec_is_jal, dec_is_jalr, dec_is_branch;
    xlen_t    rs1_val, rs2_val, op_a, op_b, jalr_sum;
    logic     br_cond, taken, ex_hit, issue;

    decoder u_decoder (
        .inst_i      (if_inst_i),
        .rs1_o       (dec_rs1),
        .rs2_o       (dec_rs2),
        .rd_o        (dec_rd),
        .imm_o       (dec_imm),
        .rd_we_o     (dec_rd_we),
        .use_rs1_o   (dec_use_rs1),
        .use_rs2_o   (dec_use_rs2),
        .src_a_pc_o  (dec_src_a_pc),
        .src_b_imm_o (dec_src_b_imm),
        .is_jal_o    (dec_is_jal),
        .is_jalr_o   (dec_is_jalr),
        .is_branch_o (dec_is_branch),
        .alu_op_o    (dec_alu_op)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .rs1_i    (dec_rs1),
        .rs2_i    (dec_rs2),
        .rdata1_o (rs1_val),
        .rdata2_o (rs2_val),
        .wb       (wb)
    );

    //////////////////////////////////////////////////
    // Branch and jump resolution
    //////////////////////////////////////////////////
    always_comb begin
        case (if_inst_i[14:12])
            F3_BEQ:  br_cond = (rs1_val == rs2_val);
            F3_BNE:  br_cond = (rs1_val != rs2_val);
            F3_BLT:  br_cond = ($signed(rs1_val) < $signed(rs2_val));
            F3_BGE:  br_cond = ($signed(rs1_val) >= $signed(rs2_val));
            F3_BLTU: br_cond = (rs1_val < rs2_val);
            F3_BGEU: br_cond = (rs1_val >= rs2_val);
            default: br_cond = 1'b0;
        endcase
    end

    // Operands not yet written back by the instruction in execute
    assign ex_hit = idex.valid && idex.rd_we &&
                    ((dec_use_rs1 && dec_rs1 == idex.rd) ||
                     (dec_use_rs2 && dec_rs2 == idex.rd));
    assign hold_o = if_valid_i && (dec_is_branch || dec_is_jalr) && ex_hit;

    assign taken      = dec_is_jal || dec_is_jalr || (dec_is_branch && br_cond);
    assign redirect_o = if_valid_i && taken && !hold_o;
    assign jalr_sum   = rs1_val + dec_imm;
    assign target_o   = dec_is_jalr ? {jalr_sum[31:1], 1'b0} : if_pc_i + dec_imm;

    // Jumps compute the link value as PC plus 4
    always_comb begin
        if (dec_src_a_pc) begin
            op_a = if_pc_i;
        end else if (dec_use_rs1) begin
            op_a = rs1_val;
        end else begin
            op_a = '0;
        end
        if (dec_src_b_imm) begin
            op_b = dec_imm;
        end else if (dec_is_jal || dec_is_jalr) begin
            op_b = 32'd4;
        end else begin
            op_b = rs2_val;
        end
    end

    //////////////////////////////////////////////////
    // Decode/execute register
    //////////////////////////////////////////////////
    assign issue = if_valid_i && !hold_o;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            idex.valid <= 1'b0;
            idex.rd_we <= 1'b0;
        end else begin
            idex.valid <= issue;
            idex.rd_we <= issue && dec_rd_we;
        end
    end

    always_ff @(posedge clk) begin
        idex.pc       <= if_pc_i;
        idex.inst     <= if_inst_i;
        idex.rd       <= dec_rd;
        idex.alu_op   <= dec_alu_op;
        idex.op_a     <= op_a;
        idex.op_b     <= op_b;
        idex.rs1      <= dec_rs1;
        idex.rs2      <= dec_rs2;
        idex.fwd_a_en <= dec_use_rs1 && !dec_src_a_pc;
        idex.fwd_b_en <= dec_use_rs2 && !dec_src_b_imm;
    end

endmodule

// ==== design/alu.sv ====
/*
 * Integer ALU
 * RV32I arithmetic, logic, compare and shift operations
 */
module alu import cpu_pkg::*; (
    input  alu_op_e op_i,
    input  xlen_t   a_i,
    input  xlen_t   b_i,
    output xlen_t   result_o
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b_i[4:0];
    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb begin
        case (op_i)
            ALU_ADD:    result_o = a_i + b_i;
            ALU_SUB:    result_o = a_i - b_i;
            ALU_SLL:    result_o = a_i << shamt;
            ALU_SLT:    result_o = {31'b0, lt_signed};
            ALU_SLTU:   result_o = {31'b0, lt_unsigned};
            ALU_XOR:    result_o = a_i ^ b_i;
            ALU_SRL:    result_o = a_i >> shamt;
            // Sign bit fills from the left
            ALU_SRA:    result_o = $signed(a_i) >>> shamt;
            ALU_OR:     result_o = a_i | b_i;
            ALU_AND:    result_o = a_i & b_i;
            ALU_PASS_B: result_o = b_i;
            default:    result_o = '0;
        endcase
    end

endmodule

// ==== design/execute_stage.sv ====
/*
 * Execute stage
 * Writeback forwarding, ALU and the execute/writeback register
 */
module execute_stage import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    id_ex_if.execute idex,
    wb_if.execute    wb
);

    xlen_t alu_a;
    xlen_t alu_b;
    xlen_t alu_result;
    logic  wb_writes;
    logic  fwd_a;
    logic  fwd_b;

    //////////////////////////////////////////////////
    // Forwarding from writeback
    //////////////////////////////////////////////////
    assign wb_writes = wb.valid && wb.rd_we;
    assign fwd_a     = idex.fwd_a_en && wb_writes && (wb.rd == idex.rs1);
    assign fwd_b     = idex.fwd_b_en && wb_writes && (wb.rd == idex.rs2);
    assign alu_a     = fwd_a ? wb.rd_data : idex.op_a;
    assign alu_b     = fwd_b ? wb.rd_data : idex.op_b;

    alu u_alu (
        .op_i     (idex.alu_op),
        .a_i      (alu_a),
        .b_i      (alu_b),
        .result_o (alu_result)
    );

    //////////////////////////////////////////////////
    // Execute/writeback register
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb.valid <= 1'b0;
            wb.rd_we <= 1'b0;
        end else begin
            wb.valid <= idex.valid;
            wb.rd_we <= idex.rd_we;
        end
    end

    always_ff @(posedge clk) begin
        wb.pc      <= idex.pc;
        wb.inst    <= idex.inst;
        wb.rd      <= idex.rd;
        wb.rd_data <= alu_result;
    end

    // Bubbles never carry a register write
    a_we_needs_valid: assert property (
        @(posedge clk) disable iff (!rst_n_i) wb.rd_we |-> wb.valid
    ) else $error("register write without a valid instruction");

endmodule

// ==== design/cpu_top.sv ====
/*
 * RV32I pipeline top level
 * Fetch, decode, execute and writeback with a retire port
 */
module cpu_top import cpu_pkg::*; #(
    parameter xlen_t RESET_PC = 32'h0000_0000
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  inst_t    imem_data_i,
    output xlen_t    imem_addr_o,
    output logic     retire_valid_o,
    output xlen_t    retire_pc_o,
    output inst_t    retire_inst_o,
    output logic     retire_rd_we_o,
    output reg_idx_t retire_rd_o,
    output xlen_t    retire_rd_data_o
);

    logic  if_valid;
    xlen_t if_pc;
    inst_t if_inst;
    logic  redirect;
    xlen_t target;
    logic  hold;

    id_ex_if idex_bus ();
    wb_if    wb_bus ();

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .redirect_i  (redirect),
        .target_i    (target),
        .hold_i      (hold),
        .imem_data_i (imem_data_i),
        .imem_addr_o (imem_addr_o),
        .if_valid_o  (if_valid),
        .if_pc_o     (if_pc),
        .if_inst_o   (if_inst)
    );

    decode_stage u_decode (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .if_valid_i (if_valid),
        .if_pc_i    (if_pc),
        .if_inst_i  (if_inst),
        .redirect_o (redirect),
        .target_o   (target),
        .hold_o     (hold),
        .idex       (idex_bus.decode),
        .wb         (wb_bus.decode)
    );

    execute_stage u_execute (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .idex    (idex_bus.execute),
        .wb      (wb_bus.execute)
    );

    // Every instruction in writeback retires
    assign retire_valid_o   = wb_bus.valid;
    assign retire_pc_o      = wb_bus.pc;
    assign retire_inst_o    = wb_bus.inst;
    assign retire_rd_we_o   = wb_bus.rd_we;
    assign retire_rd_o      = wb_bus.rd;
    assign retire_rd_data_o = wb_bus.rd_data;

endmodule

// ==== verification/tb_imem.sv ====
/*
 * Instruction ROM model
 * Word-indexed program store that answers combinationally,
 * NOP outside the loaded program
 */
module tb_imem import cpu_pkg::*; #(
    parameter xlen_t BASE  = 32'h0000_0000,
    parameter int    DEPTH = 256
) (
    input  xlen_t addr_i,
    output inst_t data_o
);
    timeunit 1ns;
    timeprecision 100ps;

    inst_t       mem [0:DEPTH-1];
    int unsigned len = 0;
    xlen_t       offset;
    logic        in_prog;

    assign offset  = addr_i - BASE;
    assign in_prog = (addr_i >= BASE) && (offset[31:2] < len);
    assign data_o  = in_prog ? mem[offset[31:2]] : NOP_INST;

    task automatic clear();
        len = 0;
    endtask

    task automatic load_word(input int unsigned idx, input inst_t word);
        mem[idx] = word;
    endtask

    // Length is set last so the read path sees the new program
    task automatic set_length(input int unsigned n);
        len = n;
    endtask

endmodule

// ==== verification/tb_cpu_top.sv ====
/*
 * Testbench for the RV32I pipeline
 * Directed programs for ALU, forwarding, branches, jumps and
 * unsupported opcodes, checked against the retire port
 */
module tb_cpu_top import cpu_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam xlen_t RESET_PC       = 32'h0000_0100;
    localparam int    RESET_CYCLES   = 16;
    localparam int    RETIRE_TIMEOUT = 20;
    localparam int    DRIVE_DELAY    = 2;

    logic     clk;
    logic     rst_n_i;
    inst_t    imem_data;
    xlen_t    imem_addr;
    logic     retire_valid_o;
    xlen_t    retire_pc_o;
    inst_t    retire_inst_o;
    logic     retire_rd_we_o;
    reg_idx_t retire_rd_o;
    xlen_t    retire_rd_data_o;

    // Program under test and its expected retirements
    inst_t    prog [$];
    xlen_t    exp_pc [$];
    inst_t    exp_inst [$];
    logic     exp_we [$];
    reg_idx_t exp_rd [$];
    xlen_t    exp_data [$];
    xlen_t    x [32];

    logic [15:0] lfsr_q;
    int          checks;
    int          errors;
    int          tests;

    cpu_top #(
        .RESET_PC (RESET_PC)
    ) dut_i (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .imem_data_i      (imem_data),
        .imem_addr_o      (imem_addr),
        .retire_valid_o   (retire_valid_o),
        .retire_pc_o      (retire_pc_o),
        .retire_inst_o    (retire_inst_o),
        .retire_rd_we_o   (retire_rd_we_o),
        .retire_rd_o      (retire_rd_o),
        .retire_rd_data_o (retire_rd_data_o)
    );

    tb_imem #(
        .BASE  (RESET_PC),
        .DEPTH (256)
    ) imem_i (
        .addr_i (imem_addr),
        .data_o (imem_data)
    );

    always #10 clk = ~clk;

    //////////////////////////////////////////////////
    // Random bits and compare tasks
    //////////////////////////////////////////////////
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    task automatic check_word(input xlen_t got, input xlen_t exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_pc(input xlen_t got, input xlen_t exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_inst(input inst_t got, input inst_t exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_idx(input reg_idx_t got, input reg_idx_t exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0t: %s is x%0d, expected x%0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////
    // Instruction encoders and ISA rules
    //////////////////////////////////////////////////
    function automatic inst_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3, reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic inst_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                    reg_idx_t rd, opcode_t opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t enc_u(logic [19:0] imm, reg_idx_t rd, opcode_t opc);
        return {imm, rd, opc};
    endfunction

    function automatic inst_t enc_b(logic [12:0] off, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic inst_t enc_j(logic [20:0] off, reg_idx_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic xlen_t sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic branch_taken(logic [2:0] f3, xlen_t a, xlen_t b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return $signed(a) < $signed(b);
            F3_BGE:  return $signed(a) >= $signed(b);
            F3_BLTU: return a < b;
            F3_BGEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Program building and running
    //////////////////////////////////////////////////
    task automatic start_program();
        prog.delete();
        exp_pc.delete();
        exp_inst.delete();
        exp_we.delete();
        exp_rd.delete();
        exp_data.delete();
        foreach (x[i]) begin
            x[i] = '0;
        end
    endtask

    function automatic xlen_t next_pc();
        return RESET_PC + 32'(prog.size() * 4);
    endfunction

    // Instruction that must retire, with its expected register write
    task automatic emit(input inst_t inst, input logic we, input xlen_t data);
        exp_pc.push_back(next_pc());
        exp_inst.push_back(inst);
        exp_we.push_back(we);
        exp_rd.push_back(inst[11:7]);
        exp_data.push_back(data);
        prog.push_back(inst);
        if (we && inst[11:7] != 5'd0) begin
            x[inst[11:7]] = data;
        end
    endtask

    // Wrong-path instruction that must never retire
    task automatic skip(input inst_t inst);
        prog.push_back(inst);
    endtask

    task automatic pulse_reset();
        @(posedge clk);
        #(DRIVE_DELAY);
        rst_n_i = 1'b0;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            check_flag(retire_valid_o, 1'b0, "retire_valid_o during reset");
        end
        check_pc(imem_addr, RESET_PC, "fetch address after reset");
        rst_n_i = 1'b1;
    endtask

    task automatic run_prog(input string name);
        int got;
        int idle;
        int errs_before;
        errs_before = errors;
        imem_i.clear();
        foreach (prog[i]) begin
            imem_i.load_word(i, prog[i]);
        end
        imem_i.set_length(prog.size());
        pulse_reset();
        got  = 0;
        idle = 0;
        while (got < exp_pc.size() && idle < RETIRE_TIMEOUT) begin
            @(negedge clk);
            idle++;
            if (retire_valid_o) begin
                check_pc(retire_pc_o, exp_pc[got], "retire pc");
                check_inst(retire_inst_o, exp_inst[got], "retire inst");
                check_flag(retire_rd_we_o, exp_we[got], "retire rd_we");
                if (exp_we[got]) begin
                    check_idx(retire_rd_o, exp_rd[got], "retire rd");
                    check_word(retire_rd_data_o, exp_data[got], "retire rd_data");
                end
                got++;
                idle = 0;
            end
        end
        if (got < exp_pc.size()) begin
            $display("Timeout in %s: only %0d of %0d instructions retired",
                     name, got, exp_pc.size());
            errors++;
        end
        tests++;
        $display("Test %s: %0d retired, %0d errors", name, got, errors - errs_before);
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////
    task automatic test_reset();
        int i;
        start_program();
        for (i = 1; i <= 6; i++) begin
            emit(enc_i(12'(i * 3), 5'(i - 1), 3'b000, 5'(i), OPC_OP_IMM), 1'b1,
                 x[i - 1] + 32'(i * 3));
        end
        run_prog("reset and straight line");
    endtask

    task automatic test_alu();
        logic [11:0] imm;
        logic [19:0] u;
        xlen_t       a;
        xlen_t       b;
        xlen_t       si;
        xlen_t       r;
        start_program();
        // Negative first operand so signed and unsigned compares differ
        imm = 12'(take_bits(12)) | 12'h800;
        emit(enc_i(imm, 0, 3'b000, 1, OPC_OP_IMM), 1'b1, sext12(imm));
        imm = 12'(take_bits(12));
        emit(enc_i(imm, 0, 3'b000, 2, OPC_OP_IMM), 1'b1, sext12(imm));
        a = x[1];
        b = x[2];
        emit(enc_r(7'h00, 2, 1, 3'b000, 3), 1'b1, a + b);
        emit(enc_r(7'h20, 2, 1, 3'b000, 4), 1'b1, a - b);
        emit(enc_r(7'h00, 2, 1, 3'b001, 5), 1'b1, a << b[4:0]);
        emit(enc_r(7'h00, 2, 1, 3'b010, 6), 1'b1, {31'b0, $signed(a) < $signed(b)});
        emit(enc_r(7'h00, 2, 1, 3'b011, 7), 1'b1, {31'b0, a < b});
        emit(enc_r(7'h00, 2, 1, 3'b100, 8), 1'b1, a ^ b);
        emit(enc_r(7'h00, 2, 1, 3'b101, 9), 1'b1, a >> b[4:0]);
        r = $signed(a) >>> b[4:0];
        emit(enc_r(7'h20, 2, 1, 3'b101, 10), 1'b1, r);
        emit(enc_r(7'h00, 2, 1, 3'b110, 11), 1'b1, a | b);
        emit(enc_r(7'h00, 2, 1, 3'b111, 12), 1'b1, a & b);
        imm = 12'(take_bits(12));
        si  = sext12(imm);
        emit(enc_i(imm, 1, 3'b000, 13, OPC_OP_IMM), 1'b1, a + si);
        emit(enc_i(imm, 1, 3'b010, 14, OPC_OP_IMM), 1'b1, {31'b0, $signed(a) < $signed(si)});
        emit(enc_i(imm, 1, 3'b011, 15, OPC_OP_IMM), 1'b1, {31'b0, a < si});
        emit(enc_i(imm, 1, 3'b100, 16, OPC_OP_IMM), 1'b1, a ^ si);
        emit(enc_i(imm, 1, 3'b110, 17, OPC_OP_IMM), 1'b1, a | si);
        emit(enc_i(imm, 1, 3'b111, 18, OPC_OP_IMM), 1'b1, a & si);
        emit(enc_i({7'h00, imm[4:0]}, 1, 3'b001, 19, OPC_OP_IMM), 1'b1, a << imm[4:0]);
        emit(enc_i({7'h00, imm[4:0]}, 1, 3'b101, 20, OPC_OP_IMM), 1'b1, a >> imm[4:0]);
        r = $signed(a) >>> imm[4:0];
        emit(enc_i({7'h20, imm[4:0]}, 1, 3'b101, 21, OPC_OP_IMM), 1'b1, r);
        u = 20'(take_bits(20));
        emit(enc_u(u, 22, OPC_LUI), 1'b1, {u, 12'b0});
        emit(enc_u(u, 23, OPC_AUIPC), 1'b1, next_pc() + {u, 12'b0});
        run_prog("alu operations");
    endtask

    task automatic test_forwarding();
        logic [11:0] imm;
        start_program();
        imm = 12'(take_bits(12));
        emit(enc_i(imm, 0, 3'b000, 1, OPC_OP_IMM), 1'b1, sext12(imm));
        imm = 12'(take_bits(12));
        emit(enc_i(imm, 0, 3'b000, 2, OPC_OP_IMM), 1'b1, sext12(imm));
        emit(enc_r(7'h00, 2, 1, 3'b000, 3), 1'b1, x[1] + x[2]);
        emit(enc_r(7'h20, 1, 3, 3'b000, 4), 1'b1, x[3] - x[1]);
        emit(enc_r(7'h00, 3, 4, 3'b100, 5), 1'b1, x[4] ^ x[3]);
        emit(enc_r(7'h00, 4, 5, 3'b000, 3), 1'b1, x[5] + x[4]);
        emit(enc_r(7'h20, 5, 3, 3'b000, 6), 1'b1, x[3] - x[5]);
        // Writes to x0 are dropped
        emit(enc_i(12'd5, 6, 3'b000, 0, OPC_OP_IMM), 1'b0, '0);
        emit(enc_r(7'h00, 6, 0, 3'b000, 7), 1'b1, x[6]);
        emit(enc_r(7'h00, 7, 1, 3'b100, 0), 1'b0, '0);
        emit(enc_r(7'h00, 0, 0, 3'b110, 8), 1'b1, '0);
        run_prog("forwarding");
    endtask

    task automatic test_branches();
        logic [2:0] f3s [6];
        xlen_t      va [3];
        xlen_t      vb [3];
        int         f;
        int         p;
        f3s = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        va  = '{32'hFFFF_FFFD, 32'd2, 32'd5};
        vb  = '{32'd2, 32'hFFFF_FFFD, 32'd5};
        start_program();
        for (f = 0; f < 6; f++) begin
            for (p = 0; p < 3; p++) begin
                emit(enc_i(va[p][11:0], 0, 3'b000, 1, OPC_OP_IMM), 1'b1, va[p]);
                // x2 is still in execute when the branch decodes
                emit(enc_i(vb[p][11:0], 0, 3'b000, 2, OPC_OP_IMM), 1'b1, vb[p]);
                emit(enc_b(13'd8, 2, 1, f3s[f]), 1'b0, '0);
                if (branch_taken(f3s[f], va[p], vb[p])) begin
                    skip(enc_i(12'd1, 0, 3'b000, 3, OPC_OP_IMM));
                end else begin
                    emit(enc_i(12'd1, 0, 3'b000, 3, OPC_OP_IMM), 1'b1, 32'd1);
                end
                emit(enc_i(12'd2, 0, 3'b000, 4, OPC_OP_IMM), 1'b1, 32'd2);
            end
        end
        run_prog("branches");
    endtask

    task automatic test_jumps();
        xlen_t pc;
        start_program();
        pc = next_pc();
        emit(enc_j(21'd12, 1), 1'b1, pc + 32'd4);
        skip(enc_i(12'd1, 0, 3'b000, 2, OPC_OP_IMM));
        skip(enc_i(12'd1, 0, 3'b000, 3, OPC_OP_IMM));
        // JALR base comes from the AUIPC right before it, bit 0 of the sum is dropped
        pc = next_pc();
        emit(enc_u(20'd0, 5, OPC_AUIPC), 1'b1, pc);
        emit(enc_i(12'd17, 5, 3'b000, 6, OPC_JALR), 1'b1, pc + 32'd8);
        skip(enc_i(12'd1, 0, 3'b000, 2, OPC_OP_IMM));
        skip(enc_i(12'd1, 0, 3'b000, 3, OPC_OP_IMM));
        emit(enc_r(7'h20, 1, 6, 3'b000, 7), 1'b1, x[6] - x[1]);
        emit(enc_j(21'd8, 0), 1'b0, '0);
        skip(enc_i(12'd1, 0, 3'b000, 2, OPC_OP_IMM));
        emit(enc_i(12'd9, 7, 3'b000, 8, OPC_OP_IMM), 1'b1, x[7] + 32'd9);
        run_prog("jumps");
    endtask

    task automatic test_unsupported();
        start_program();
        emit(enc_i(12'd7, 0, 3'b000, 9, OPC_OP_IMM), 1'b1, 32'd7);
        // Load, CSR access and multiply all retire without a write
        emit(enc_i(12'd0, 9, 3'b010, 9, 7'b0000011), 1'b0, '0);
        emit(enc_i(12'h001, 0, 3'b001, 11, 7'b1110011), 1'b0, '0);
        emit(enc_r(7'h01, 9, 9, 3'b000, 12), 1'b0, '0);
        emit(enc_i(12'd1, 9, 3'b000, 10, OPC_OP_IMM), 1'b1, 32'd8);
        emit(enc_r(7'h00, 12, 11, 3'b110, 13), 1'b1, '0);
        run_prog("unsupported opcodes");
    endtask

    initial begin
        clk     = 1'b0;
        rst_n_i = 1'b0;
        lfsr_q  = 16'd34;
        checks  = 0;
        errors  = 0;
        tests   = 0;
        test_reset();
        test_alu();
        test_forwarding();
        test_branches();
        test_jumps();
        test_unsupported();
        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
design/cpu_pkg.sv
design/cpu_intf.sv
design/fetch_stage.sv
design/decoder.sv
design/reg_file.sv
design/decode_stage.sv
design/alu.sv
design/execute_stage.sv
design/cpu_top.sv
verification/tb_imem.sv
verification/tb_cpu_top.sv

// ==== Bender.yml ====
package:
  name: rv32i_pipeline

sources:
  - files:
      - design/cpu_pkg.sv
      - design/cpu_intf.sv
      - design/fetch_stage.sv
      - design/decoder.sv
      - design/reg_file.sv
      - design/decode_stage.sv
      - design/alu.sv
      - design/execute_stage.sv
      - design/cpu_top.sv
  - target: test
    files:
      - verification/tb_imem.sv
      - verification/tb_cpu_top.sv
